// ==== tb/fpu_tests.txt ====
# op a b int16_in result secondary has_secondary int16_out flags chain
# Hex fields, flags in binary as invalid denormal overflow, chain 1 sends the next test at once
17 4002A000000000000000 00000000000000000000 0000 3FFFA000000000000000 4000C000000000000000 1 0000 000 0
17 BFFDC000000000000000 00000000000000000000 0000 BFFFC000000000000000 C0008000000000000000 1 0000 000 0
17 00000000000000000000 00000000000000000000 0000 00000000000000000000 FFFF8000000000000000 1 0000 000 0
17 3FFF8000000000000000 00000000000000000000 0000 3FFF8000000000000000 00000000000000000000 1 0000 000 0
18 3FFFC000000000000000 4000C000000000000000 0000 4002C000000000000000 00000000000000000000 0 0000 000 0
18 3FFFC000000000000000 C0008000000000000000 0000 3FFDC000000000000000 00000000000000000000 0 0000 000 0
18 3FFFC000000000000000 4000B000000000000000 0000 4001C000000000000000 00000000000000000000 0 0000 000 0
18 3FFFC000000000000000 3FFE8000000000000000 0000 3FFFC000000000000000 00000000000000000000 0 0000 000 0
18 7FFE8000000000000000 40008000000000000000 0000 7FFF8000000000000000 00000000000000000000 0 0000 001 0
18 7FFFC000000000000000 3FFF8000000000000000 0000 7FFFC000000000000000 00000000000000000000 0 0000 000 0
18 3FFF8000000000000000 C00D9C40000000000000 0000 00000000000000000000 00000000000000000000 0 0000 000 0
18 00000000000000000001 3FFF8000000000000000 0000 00010000000000000001 00000000000000000000 0 0000 010 0
06 00000000000000000001 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 0000 000 0
04 00000000000000000000 00000000000000000000 0001 3FFF8000000000000000 00000000000000000000 0 0000 000 1
04 00000000000000000000 00000000000000000000 FFFB C001A000000000000000 00000000000000000000 0 0000 000 1
04 00000000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 0000 000 1
04 00000000000000000000 00000000000000000000 8000 C00E8000000000000000 00000000000000000000 0 0000 000 1
04 00000000000000000000 00000000000000000000 7FFF 400DFFFE000000000000 00000000000000000000 0 0000 000 0
06 4000B000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 0002 000 1
06 C000B000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 FFFE 000 1
06 400E9C40000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 8000 100 1
06 C00E8000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 8000 000 1
06 7FFFC000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 8000 100 0
01 3FFF8000000000000000 00000000000000000000 0000 00000000000000000000 00000000000000000000 0 0000 000 0

// ==== all.f ====
source/fpu_pkg.sv
source/fp_result_if.sv
source/fp_extract.sv
source/fp_scale.sv
source/int16_convert.sv
source/fpu_result_select.sv
source/fpu_bitops_unit.sv
tb/tb_fpu_bitops.sv

// ==== Makefile ====
TOP := tb_fpu_bitops

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== tb/tb_fpu_bitops.sv ====
// FPU bit operations testbench
`timescale 1ns/10ps

module tb_fpu_bitops;

    localparam string TEST_FILE = "tb/fpu_tests.txt";

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [4:0]  operation;
    logic [79:0] operand_a;
    logic [79:0] operand_b;
    logic [15:0] int16_in;
    logic [79:0] result;
    logic [79:0] result_secondary;
    logic        has_secondary;
    logic [15:0] int16_out;
    logic        done;
    logic        flag_invalid;
    logic        flag_denormal;
    logic        flag_overflow;

    // One entry per test line
    logic [4:0]  t_op[$];
    logic [79:0] t_a[$];
    logic [79:0] t_b[$];
    logic [15:0] t_int_in[$];
    logic [79:0] t_res[$];
    logic [79:0] t_sec[$];
    logic        t_has_sec[$];
    logic [15:0] t_int_out[$];
    logic [2:0]  t_flags[$];
    logic        t_chain[$];

    int pass_count = 0;
    int fail_count = 0;
    int load_errors = 0;
    bit loaded = 1'b0;

    fpu_bitops_unit u_fpu_bitops_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .enable           (enable),
        .operation        (fpu_pkg::fpu_op_t'(operation)),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .int16_in         (int16_in),
        .result           (result),
        .result_secondary (result_secondary),
        .has_secondary    (has_secondary),
        .int16_out        (int16_out),
        .done             (done),
        .flag_invalid     (flag_invalid),
        .flag_denormal    (flag_denormal),
        .flag_overflow    (flag_overflow)
    );

    // ==============================
    // Clock and watchdog
    // ==============================

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Two cycles per test at most, plus reset and slack
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(t_op.size()) + 10) * 200;
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
    end

    // Only the four kept codes ever raise done
    function automatic logic op_is_kept(input logic [4:0] op);
        return (op == 5'd4) || (op == 5'd6) || (op == 5'd23) || (op == 5'd24);
    endfunction

    // ==============================
    // Test file loading
    // ==============================

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        logic [4:0]  op;
        logic [79:0] a;
        logic [79:0] b;
        logic [15:0] ii;
        logic [79:0] er;
        logic [79:0] es;
        logic        eh;
        logic [15:0] ei;
        logic [2:0]  ef;
        logic        ch;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank and comment lines
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %b %h",
                              op, a, b, ii, er, es, eh, ei, ef, ch);
                if (cnt != 10) begin
                    $display("Malformed test line: %s", line);
                    load_errors++;
                end else begin
                    t_op.push_back(op);
                    t_a.push_back(a);
                    t_b.push_back(b);
                    t_int_in.push_back(ii);
                    t_res.push_back(er);
                    t_sec.push_back(es);
                    t_has_sec.push_back(eh);
                    t_int_out.push_back(ei);
                    t_flags.push_back(ef);
                    t_chain.push_back(ch);
                end
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // Drive and check
    // ==============================

    task automatic apply_test(input int i);
        enable    <= 1'b1;
        operation <= t_op[i];
        operand_a <= t_a[i];
        operand_b <= t_b[i];
        int16_in  <= t_int_in[i];
    endtask

    task automatic apply_idle();
        enable    <= 1'b0;
        operation <= '0;
        operand_a <= '0;
        operand_b <= '0;
        int16_in  <= '0;
    endtask

    task automatic report_mismatch(input int i, input string field,
                                   input logic [79:0] got, input logic [79:0] exp);
        $display("** Error at %0t: test %0d %s got %h expected %h", $time, i, field, got, exp);
    endtask

    task automatic check_outputs(input int i);
        logic ok;
        logic exp_done;
        ok = 1'b1;
        exp_done = op_is_kept(t_op[i]);
        if (done !== exp_done) begin
            report_mismatch(i, "done", 80'(done), 80'(exp_done));
            ok = 1'b0;
        end
        if (result !== t_res[i]) begin
            report_mismatch(i, "result", result, t_res[i]);
            ok = 1'b0;
        end
        if (result_secondary !== t_sec[i]) begin
            report_mismatch(i, "result_secondary", result_secondary, t_sec[i]);
            ok = 1'b0;
        end
        if (has_secondary !== t_has_sec[i]) begin
            report_mismatch(i, "has_secondary", 80'(has_secondary), 80'(t_has_sec[i]));
            ok = 1'b0;
        end
        if (int16_out !== t_int_out[i]) begin
            report_mismatch(i, "int16_out", 80'(int16_out), 80'(t_int_out[i]));
            ok = 1'b0;
        end
        // Flag order is invalid, denormal, overflow
        if ({flag_invalid, flag_denormal, flag_overflow} !== t_flags[i]) begin
            report_mismatch(i, "flags", 80'({flag_invalid, flag_denormal, flag_overflow}),
                            80'(t_flags[i]));
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("Test %0d op %0d: ok", i, t_op[i]);
        end else begin
            fail_count++;
            $display("Test %0d op %0d: mismatch", i, t_op[i]);
        end
    endtask

    initial begin
        int i;
        bit pending;
        rst_n     = 1'b0;
        enable    = 1'b0;
        operation = '0;
        operand_a = '0;
        operand_b = '0;
        int16_in  = '0;
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        if (load_errors == 0) begin
            i = 0;
            pending = 1'b0;
            while (i < t_op.size()) begin
                if (!pending) begin
                    @(posedge clk);
                    apply_test(i);
                end
                // DUT samples test i here, a chained test goes in on the same edge
                @(posedge clk);
                if (t_chain[i] && (i + 1 < t_op.size())) begin
                    apply_test(i + 1);
                    pending = 1'b1;
                end else begin
                    apply_idle();
                    pending = 1'b0;
                end
                @(negedge clk);
                check_outputs(i);
                i++;
            end
        end
        @(posedge clk);
        $display("Tests run %0d, passed %0d, failed %0d", t_op.size(), pass_count, fail_count);
        if (fail_count == 0 && load_errors == 0 && t_op.size() > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== source/fpu_bitops_unit.sv ====
// FPU bit operations unit
`timescale 1ns/10ps

module fpu_bitops_unit
    import fpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    input  fpu_op_t  operation,
    input  fp80_t    operand_a,
    input  fp80_t    operand_b,
    input  int16_t_w int16_in,
    output fp80_t    result,
    output fp80_t    result_secondary,
    output logic     has_secondary,
    output int16_t_w int16_out,
    output logic     done,
    output logic     flag_invalid,
    output logic     flag_denormal,
    output logic     flag_overflow
);

    // One result bus per operation unit
    fp_result_if xtr_bus ();
    fp_result_if scl_bus ();
    fp_result_if cnv_bus ();

    // ==============================
    // Operation units
    // ==============================

    fp_extract u_fp_extract (
        .operand_a (operand_a),
        .bus       (xtr_bus.unit)
    );

    fp_scale u_fp_scale (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .bus       (scl_bus.unit)
    );

    int16_convert u_int16_convert (
        .operation (operation),
        .operand_a (operand_a),
        .int16_in  (int16_in),
        .bus       (cnv_bus.unit)
    );

    // Registered selection, one cycle after enable
    fpu_result_select u_fpu_result_select (
        .clk              (clk),
        .rst_n            (rst_n),
        .enable           (enable),
        .operation        (operation),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .xtr              (xtr_bus.sel),
        .scl              (scl_bus.sel),
        .cnv              (cnv_bus.sel),
        .result           (result),
        .result_secondary (result_secondary),
        .has_secondary    (has_secondary),
        .int16_out        (int16_out),
        .done             (done),
        .flag_invalid     (flag_invalid),
        .flag_denormal    (flag_denormal),
        .flag_overflow    (flag_overflow)
    );

endmodule

// ==== source/fpu_result_select.sv ====
// FPU result select and output register
`timescale 1ns/10ps

module fpu_result_select
    import fpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      enable,
    input  fpu_op_t   operation,
    input  fp80_t     operand_a,
    input  fp80_t     operand_b,
    fp_result_if.sel  xtr,
    fp_result_if.sel  scl,
    fp_result_if.sel  cnv,
    output fp80_t     result,
    output fp80_t     result_secondary,
    output logic      has_secondary,
    output int16_t_w  int16_out,
    output logic      done,
    output logic      flag_invalid,
    output logic      flag_denormal,
    output logic      flag_overflow
);

    logic     op_kept;
    logic     fire;
    logic     to_int;
    logic     denorm;
    fp80_t    pick_res;
    fp80_t    pick_sec;
    logic     pick_has_sec;
    int16_t_w pick_int;
    logic     pick_inv;
    logic     pick_ovf;

    // ==============================
    // Operation decode
    // ==============================

    always_comb begin
        op_kept = 1'b1;
        case (operation)
            OP_FXTRACT: begin
                {pick_res, pick_sec, pick_has_sec} = {xtr.result, xtr.result_secondary,
                                                      xtr.has_secondary};
                {pick_int, pick_inv, pick_ovf} = {xtr.int_result, xtr.invalid, xtr.overflow};
            end
            OP_FSCALE: begin
                {pick_res, pick_sec, pick_has_sec} = {scl.result, scl.result_secondary,
                                                      scl.has_secondary};
                {pick_int, pick_inv, pick_ovf} = {scl.int_result, scl.invalid, scl.overflow};
            end
            OP_INT16_TO_FP, OP_FP_TO_INT16: begin
                {pick_res, pick_sec, pick_has_sec} = {cnv.result, cnv.result_secondary,
                                                      cnv.has_secondary};
                {pick_int, pick_inv, pick_ovf} = {cnv.int_result, cnv.invalid, cnv.overflow};
            end
            default: begin
                // Unknown codes never complete
                op_kept = 1'b0;
                {pick_res, pick_sec, pick_has_sec} = '0;
                {pick_int, pick_inv, pick_ovf} = '0;
            end
        endcase
    end

    assign fire   = enable && op_kept;
    assign to_int = (operation == OP_FP_TO_INT16);
    // Denormal check skips the conversions
    assign denorm = ((operation == OP_FXTRACT) || (operation == OP_FSCALE)) &&
                    (is_denormal(operand_a) || is_denormal(operand_b));

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done             <= 1'b0;
            result           <= '0;
            result_secondary <= '0;
            has_secondary    <= 1'b0;
            int16_out        <= '0;
            flag_invalid     <= 1'b0;
            flag_denormal    <= 1'b0;
            flag_overflow    <= 1'b0;
        end else begin
            // Everything drops back to zero outside the done cycle
            done             <= fire;
            result           <= (fire && !to_int) ? pick_res : '0;
            result_secondary <= (fire && !to_int) ? pick_sec : '0;
            has_secondary    <= fire && !to_int && pick_has_sec;
            int16_out        <= (fire && to_int) ? pick_int : '0;
            flag_invalid     <= fire && pick_inv;
            flag_denormal    <= fire && denorm;
            flag_overflow    <= fire && pick_ovf;
        end
    end

    // Every done pulse traces back to an enable one cycle earlier
    a_done_after_enable: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> $past(enable)
    );

    // Secondary result only shows up alongside done
    a_secondary_in_done: assert property (
        @(posedge clk) disable iff (!rst_n) has_secondary |-> done
    );

endmodule

// ==== source/int16_convert.sv ====
// Int16 and FP80 conversions
`timescale 1ns/10ps

module int16_convert
    import fpu_pkg::*;
(
    input  fpu_op_t   operation,
    input  fp80_t     operand_a,
    input  int16_t_w  int16_in,
    fp_result_if.unit bus
);

    logic [16:0] a_int;
    fp80_t       fp_res;
    int16_t_w    int_res;
    logic        inv;

    always_comb begin
        a_int   = int_part(operand_a);
        fp_res  = '0;
        int_res = '0;
        inv     = 1'b0;

        case (operation)
            // ==============================
            // Integer to extended
            // ==============================
            OP_INT16_TO_FP: begin
                // Always exact, 16 bits fit in the significand
                fp_res = int16_to_fp80(int16_in);
            end

            // ==============================
            // Extended to integer
            // ==============================
            OP_FP_TO_INT16: begin
                if (is_nan(operand_a) || is_inf(operand_a) || a_int[16]) begin
                    int_res = INT16_INDEFINITE;
                    inv     = 1'b1;
                end else if (operand_a[79]) begin
                    // Negative side reaches down to -32768
                    if (a_int[15:0] > 16'h8000) begin
                        int_res = INT16_INDEFINITE;
                        inv     = 1'b1;
                    end else begin
                        int_res = ~a_int[15:0] + 16'd1;
                    end
                end else if (a_int[15]) begin
                    // Positive magnitude above 32767
                    int_res = INT16_INDEFINITE;
                    inv     = 1'b1;
                end else begin
                    int_res = a_int[15:0];
                end
            end

            default: begin
                inv = 1'b0;
            end
        endcase
    end

    assign bus.result           = fp_res;
    assign bus.result_secondary = '0;
    assign bus.has_secondary    = 1'b0;
    assign bus.int_result       = int_res;
    assign bus.invalid          = inv;
    assign bus.overflow         = 1'b0;

endmodule

// ==== source/fp_scale.sv ====
// FSCALE exponent adjustment
`timescale 1ns/10ps

module fp_scale
    import fpu_pkg::*;
(
    input  fp80_t     operand_a,
    input  fp80_t     operand_b,
    fp_result_if.unit bus
);

    logic [16:0]       b_int;
    logic signed [18:0] scale;
    logic signed [18:0] new_exp;
    fp80_t             scaled;
    logic              ovf;

    // ==============================
    // Scale from operand b
    // ==============================

    always_comb begin
        b_int = int_part(operand_b);
        if (b_int[16]) begin
            // Huge scales saturate, result is out of range anyway
            scale = operand_b[79] ? -19'(SCALE_LIMIT) : 19'(SCALE_LIMIT);
        end else if (operand_b[79]) begin
            scale = -$signed({2'b00, b_int});
        end else begin
            scale = $signed({2'b00, b_int});
        end
        // Headroom for 32767 plus the largest unsaturated scale
        new_exp = $signed({4'b0000, operand_a[78:64]}) + scale;
    end

    // ==============================
    // Special cases and range check
    // ==============================

    always_comb begin
        ovf = 1'b0;
        if (is_nan(operand_a) || is_nan(operand_b)) begin
            // First NaN wins
            scaled = is_nan(operand_a) ? operand_a : operand_b;
        end else if (is_zero(operand_a) || is_inf(operand_a)) begin
            scaled = operand_a;
        end else if (is_inf(operand_b)) begin
            // 2^-inf collapses to zero, 2^+inf blows up
            scaled = operand_b[79] ? make_zero(operand_a[79]) : make_inf(operand_a[79]);
        end else if (new_exp > $signed({4'b0000, EXP_NORMAL_MAX})) begin
            scaled = make_inf(operand_a[79]);
            ovf = 1'b1;
        end else if (new_exp < 19'sd1) begin
            scaled = make_zero(operand_a[79]);
        end else begin
            // Significand untouched, only the exponent moves
            scaled = {operand_a[79], new_exp[14:0], operand_a[63:0]};
        end
    end

    assign bus.result           = scaled;
    assign bus.result_secondary = '0;
    assign bus.has_secondary    = 1'b0;
    assign bus.int_result       = '0;
    assign bus.invalid          = 1'b0;
    assign bus.overflow         = ovf;

endmodule

// ==== source/fp_extract.sv ====
// FXTRACT significand and exponent split
`timescale 1ns/10ps

module fp_extract
    import fpu_pkg::*;
(
    input  fp80_t     operand_a,
    fp_result_if.unit bus
);

    fp80_t    significand;
    fp80_t    exponent;
    int16_t_w unbiased;

    always_comb begin
        // True exponent, always fits in 16 signed bits
        unbiased = {1'b0, operand_a[78:64]} - {1'b0, EXP_BIAS};

        // Special values pass straight through
        if (is_zero(operand_a) || is_inf(operand_a) || is_nan(operand_a)) begin
            significand = operand_a;
        end else begin
            // Rebias so the value lands in [1.0, 2.0)
            significand = {operand_a[79], EXP_BIAS, operand_a[63:0]};
        end

        if (is_zero(operand_a)) begin
            // Zero gives negative infinity
            exponent = make_inf(1'b1);
        end else if (is_inf(operand_a)) begin
            exponent = make_inf(1'b0);
        end else if (is_nan(operand_a)) begin
            exponent = operand_a;
        end else begin
            exponent = int16_to_fp80(unbiased);
        end
    end

    // ==============================
    // Bus outputs
    // ==============================

    assign bus.result           = significand;
    assign bus.result_secondary = exponent;
    assign bus.has_secondary    = 1'b1;
    assign bus.int_result       = '0;
    // FXTRACT never traps here
    assign bus.invalid          = 1'b0;
    assign bus.overflow         = 1'b0;

endmodule

// ==== source/fp_result_if.sv ====
// Operation unit result bus
`timescale 1ns/10ps

interface fp_result_if
    import fpu_pkg::*;
();

    fp80_t    result;
    // Second value, only FXTRACT fills it
    fp80_t    result_secondary;
    logic     has_secondary;
    int16_t_w int_result;
    logic     invalid;
    logic     overflow;

    // Unit side drives everything
    modport unit (
        output result,
        output result_secondary,
        output has_secondary,
        output int_result,
        output invalid,
        output overflow
    );

    // Selector side only reads
    modport sel (
        input result,
        input result_secondary,
        input has_secondary,
        input int_result,
        input invalid,
        input overflow
    );

endinterface

// ==== source/fpu_pkg.sv ====
// FPU bit operations package
package fpu_pkg;

    // ==============================
    // Types
    // ==============================

    // Extended value is sign, biased exponent and explicit-integer significand
    typedef logic [79:0] fp80_t;
    typedef logic [14:0] fp_exp_t;
    typedef logic [63:0] fp_mant_t;
    typedef logic signed [15:0] int16_t_w;

    // Operation codes keep the numbering of the full arithmetic unit
    typedef enum logic [4:0] {
        OP_INT16_TO_FP = 5'd4,
        OP_FP_TO_INT16 = 5'd6,
        OP_FXTRACT     = 5'd23,
        OP_FSCALE      = 5'd24
    } fpu_op_t;

    // ==============================
    // Field constants
    // ==============================

    localparam fp_exp_t  EXP_BIAS         = 15'd16383;
    localparam fp_exp_t  EXP_MAX          = 15'd32767;
    localparam fp_exp_t  EXP_NORMAL_MAX   = 15'd32766;
    localparam int       SCALE_LIMIT      = 16384;
    localparam fp_mant_t MANT_INF         = 64'h8000_0000_0000_0000;
    localparam int16_t_w INT16_INDEFINITE = 16'sh8000;

    // ==============================
    // Classification helpers
    // ==============================

    function automatic logic is_zero(input fp80_t v);
        return (v[78:64] == '0) && (v[63:0] == '0);
    endfunction

    function automatic logic is_inf(input fp80_t v);
        return (v[78:64] == EXP_MAX) && (v[63:0] == MANT_INF);
    endfunction

    // Any all-ones exponent that is not exactly infinity
    function automatic logic is_nan(input fp80_t v);
        return (v[78:64] == EXP_MAX) && (v[63:0] != MANT_INF);
    endfunction

    function automatic logic is_denormal(input fp80_t v);
        return (v[78:64] == '0) && (v[63:0] != '0);
    endfunction

    function automatic fp80_t make_inf(input logic sign);
        return {sign, EXP_MAX, MANT_INF};
    endfunction

    function automatic fp80_t make_zero(input logic sign);
        return {sign, 79'd0};
    endfunction

    // Integer part of |v| truncated toward zero
    // Bit 16 marks a magnitude of 2^16 or more
    function automatic logic [16:0] int_part(input fp80_t v);
        fp_exp_t  e;
        fp_mant_t m;
        logic [5:0] sh;
        e = v[78:64];
        if (e < EXP_BIAS) begin
            return '0;
        end
        if (e > EXP_BIAS + 15'd15) begin
            return 17'h1_0000;
        end
        // Integer bit sits at bit 63, so shift the fraction out
        sh = 6'd63 - 6'(e - EXP_BIAS);
        m = v[63:0] >> sh;
        return {1'b0, m[15:0]};
    endfunction

    // Exact conversion of a signed 16-bit integer
    function automatic fp80_t int16_to_fp80(input int16_t_w val);
        logic [15:0] mag;
        logic [3:0]  msb;
        fp_exp_t     e;
        fp_mant_t    m;
        if (val == '0) begin
            return make_zero(1'b0);
        end
        mag = val[15] ? (~val + 16'd1) : val;
        // Leading one search, highest set bit wins
        msb = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (mag[i]) begin
                msb = 4'(i);
            end
        end
        e = EXP_BIAS + fp_exp_t'(msb);
        m = fp_mant_t'(mag) << (6'd63 - {2'b00, msb});
        return {val[15], e, m};
    endfunction

endpackage
